/* hw/ddr3_pkg.sv */
package ddr3_pkg;

  // Command codes double as the {RAS#, CAS#, WE#} pin levels
  typedef enum logic [2:0] {
    CMD_MODE = 3'b000,  // Mode register set
    CMD_REFR = 3'b001,  // Auto refresh
    CMD_PREC = 3'b010,  // Precharge
    CMD_ZQCL = 3'b110,  // ZQ calibration
    CMD_NOP  = 3'b111
  } ddr3_cmd_t;

  typedef logic [2:0] ddr3_ba_t;   // Bank address
  typedef logic [12:0] ddr3_adr_t;  // Row or column address

  // Wide enough for the longest gap (ZQ init)
  typedef logic [9:0] ddr3_gap_t;

  // One command request from the init sequencer or the refresh timer
  typedef struct packed {
    ddr3_cmd_t cmd;
    ddr3_ba_t  ba;
    ddr3_adr_t adr;
  } ddr3_req_t;

  // Command as it appears on the device pins
  typedef struct packed {
    logic      cs_n;
    logic      ras_n;
    logic      cas_n;
    logic      we_n;
    ddr3_ba_t  ba;
    ddr3_adr_t adr;
  } ddr3_pins_t;

  // Mode-register contents
  // MR0 with WR 6, DLL reset, CL 6 and burst length 8
  localparam ddr3_adr_t MR0 = 13'h0520;
  localparam ddr3_adr_t MR1 = 13'h0002;  // DLL on, RZQ/7 drive, no ODT
  localparam ddr3_adr_t MR2 = 13'h0000;  // CWL 5
  localparam ddr3_adr_t MR3 = 13'h0000;  // Normal data path

  // Minimum cycles from a command to the next one
  localparam int GAP_MRD    = 4;    // After MR1..MR3
  localparam int GAP_MOD    = 12;   // After MR0
  localparam int GAP_ZQINIT = 512;
  localparam int GAP_RP     = 5;
  localparam int GAP_RFC    = 64;

  // Postponed refreshes allowed by JEDEC
  localparam int REFRESH_PENDING_MAX = 8;

endpackage

/* hw/ddr3_init_seq.sv */
module ddr3_init_seq #(
  parameter int RSTN_CYCLES = 200,
  parameter int CKE_CYCLES  = 500
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                rdy_i,
  output logic                req_o,
  output ddr3_pkg::ddr3_req_t cmd_o,
  output logic                reset_n_o,
  output logic                cke_o,
  output logic                run_o
);

  // One counter serves both power-up phases
  localparam int CNT_MAX = (RSTN_CYCLES > CKE_CYCLES) ? RSTN_CYCLES : CKE_CYCLES;
  localparam int CNT_W = $clog2(CNT_MAX + 1);

  typedef enum logic [3:0] {
    ST_RSTN = 4'b0000,  // RESET# held low
    ST_INIT = 4'b0001,  // CKE held low
    ST_CKE1 = 4'b0010,
    ST_MRS2 = 4'b1010,
    ST_MRS3 = 4'b1011,
    ST_MRS1 = 4'b1001,
    ST_MRS0 = 4'b1000,
    ST_ZQCL = 4'b0011,
    ST_PREA = 4'b0100,
    ST_DONE = 4'b0101
  } init_state_t;

  init_state_t         state_q;
  logic [CNT_W-1:0]    count_q;
  logic                req_q;
  logic                reset_n_q;
  logic                cke_q;
  logic                run_q;
  ddr3_pkg::ddr3_req_t cmd_q;
  logic                load_cmd;

  // Request that goes out when leaving the given state
  function automatic ddr3_pkg::ddr3_req_t next_req(init_state_t st);
    ddr3_pkg::ddr3_req_t r;
    r.cmd = ddr3_pkg::CMD_MODE;
    r.ba  = 3'd0;
    r.adr = 13'h0000;
    case (st)
      ST_CKE1: begin
        r.ba  = 3'd2;
        r.adr = ddr3_pkg::MR2;
      end
      ST_MRS2: begin
        r.ba  = 3'd3;
        r.adr = ddr3_pkg::MR3;
      end
      ST_MRS3: begin
        r.ba  = 3'd1;
        r.adr = ddr3_pkg::MR1;
      end
      ST_MRS1: r.adr = ddr3_pkg::MR0;
      ST_MRS0: begin
        r.cmd = ddr3_pkg::CMD_ZQCL;
        r.adr = 13'h0400;  // A10 high selects the long calibration
      end
      default: r.cmd = ddr3_pkg::CMD_PREC;  // Issuer adds A10 for all banks
    endcase
    return r;
  endfunction

  // Advance right after CKE, then on each rdy pulse
  assign load_cmd = (state_q == ST_CKE1) ||
                    (rdy_i && (state_q inside {ST_MRS2, ST_MRS3, ST_MRS1, ST_MRS0, ST_ZQCL}));

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= ST_RSTN;
      count_q   <= CNT_W'(RSTN_CYCLES - 1);
      req_q     <= 1'b0;
      reset_n_q <= 1'b0;
      cke_q     <= 1'b0;
      run_q     <= 1'b0;
    end else begin
      case (state_q)
        ST_RSTN: begin
          if (count_q == '0) begin
            state_q   <= ST_INIT;
            reset_n_q <= 1'b1;  // Device starts its internal init
            count_q   <= CNT_W'(CKE_CYCLES - 1);
          end else begin
            count_q <= count_q - 1'b1;
          end
        end
        ST_INIT: begin
          if (count_q == '0) begin
            state_q <= ST_CKE1;
            cke_q   <= 1'b1;
          end else begin
            count_q <= count_q - 1'b1;
          end
        end
        ST_CKE1: begin
          state_q <= ST_MRS2;
          req_q   <= 1'b1;  // First MRS goes out
        end
        ST_MRS2: if (rdy_i) state_q <= ST_MRS3;
        ST_MRS3: if (rdy_i) state_q <= ST_MRS1;
        ST_MRS1: if (rdy_i) state_q <= ST_MRS0;
        ST_MRS0: if (rdy_i) state_q <= ST_ZQCL;
        ST_ZQCL: if (rdy_i) state_q <= ST_PREA;
        ST_PREA: begin
          if (rdy_i) begin
            state_q <= ST_DONE;
            req_q   <= 1'b0;
            run_q   <= 1'b1;  // Hand over to refresh
          end
        end
        ST_DONE: ;  // Stay here until the next reset
        default: begin
          state_q   <= ST_RSTN;
          count_q   <= CNT_W'(RSTN_CYCLES - 1);
          req_q     <= 1'b0;
          reset_n_q <= 1'b0;
          cke_q     <= 1'b0;
          run_q     <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (load_cmd) begin
      cmd_q <= next_req(state_q);
    end
  end

  assign req_o     = req_q;
  assign cmd_o     = cmd_q;
  assign reset_n_o = reset_n_q;
  assign cke_o     = cke_q;
  assign run_o     = run_q;

endmodule

/* hw/ddr3_refresh_timer.sv */
module ddr3_refresh_timer #(
  parameter int REFI_CYCLES = 780
) (
  input  logic clock,
  input  logic reset,
  input  logic run_i,
  input  logic done_i,
  output logic req_o
);

  localparam int CNT_W = $clog2(REFI_CYCLES + 1);
  localparam int PEND_W = $clog2(ddr3_pkg::REFRESH_PENDING_MAX + 1);

  localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(REFI_CYCLES - 1);
  localparam logic [PEND_W-1:0] PEND_MAX = PEND_W'(ddr3_pkg::REFRESH_PENDING_MAX);

  logic [CNT_W-1:0]  cnt_q;
  logic [PEND_W-1:0] pend_q;  // Refreshes owed to the device
  logic              expire;

  // One interval has passed
  assign expire = run_i && (cnt_q == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      cnt_q <= CNT_RELOAD;
    end else if (!run_i || expire) begin
      cnt_q <= CNT_RELOAD;  // Idle until init is done
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Saturating pending count
  always_ff @(posedge clock) begin
    if (reset) begin
      pend_q <= '0;
    end else begin
      case ({expire, done_i})
        2'b10: begin
          if (pend_q != PEND_MAX) begin
            pend_q <= pend_q + 1'b1;
          end
        end
        2'b01: begin
          if (pend_q != '0) begin
            pend_q <= pend_q - 1'b1;
          end
        end
        default: ;  // Both or neither leave it as is
      endcase
    end
  end

  assign req_o = (pend_q != '0);

endmodule

/* hw/ddr3_cmd_issue.sv */
module ddr3_cmd_issue (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 run_i,
  input  logic                 busy_i,
  input  logic                 init_req_i,
  input  ddr3_pkg::ddr3_req_t  init_cmd_i,
  input  logic                 ref_req_i,
  output logic                 init_rdy_o,
  output logic                 ref_done_o,
  output ddr3_pkg::ddr3_pins_t pins_o
);

  // Deselected bus with NOP levels
  localparam ddr3_pkg::ddr3_pins_t PINS_IDLE = '{
    cs_n:  1'b1,
    ras_n: 1'b1,
    cas_n: 1'b1,
    we_n:  1'b1,
    ba:    '0,
    adr:   '0
  };

  ddr3_pkg::ddr3_gap_t  gap_q;       // Cycles left before the next command
  logic                 rdy_q;
  logic                 done_q;
  logic                 src_init_q;  // Command in flight came from init
  ddr3_pkg::ddr3_pins_t pins_q;

  logic                 idle;
  logic                 accept_init;
  logic                 accept_ref;
  logic                 accept;
  ddr3_pkg::ddr3_req_t  sel_req;
  ddr3_pkg::ddr3_adr_t  sel_adr;

  // Minimum gap after a command
  function automatic ddr3_pkg::ddr3_gap_t gap_of(ddr3_pkg::ddr3_req_t r);
    ddr3_pkg::ddr3_gap_t g;
    case (r.cmd)
      ddr3_pkg::CMD_MODE: begin
        if (r.ba == 3'd0) begin
          g = ddr3_pkg::ddr3_gap_t'(ddr3_pkg::GAP_MOD);  // MR0 needs tMOD
        end else begin
          g = ddr3_pkg::ddr3_gap_t'(ddr3_pkg::GAP_MRD);
        end
      end
      ddr3_pkg::CMD_ZQCL: g = ddr3_pkg::ddr3_gap_t'(ddr3_pkg::GAP_ZQINIT);
      ddr3_pkg::CMD_PREC: g = ddr3_pkg::ddr3_gap_t'(ddr3_pkg::GAP_RP);
      ddr3_pkg::CMD_REFR: g = ddr3_pkg::ddr3_gap_t'(ddr3_pkg::GAP_RFC);
      default:            g = ddr3_pkg::ddr3_gap_t'(1);
    endcase
    return g;
  endfunction

  assign idle = (gap_q == '0);

  // Init owns the bus before run and refresh after it
  // The rdy cycle still sees the old init request so it is skipped
  assign accept_init = idle && !rdy_q && !run_i && init_req_i;
  assign accept_ref  = idle && run_i && !busy_i && ref_req_i;
  assign accept      = accept_init || accept_ref;

  always_comb begin
    if (accept_ref) begin
      sel_req.cmd = ddr3_pkg::CMD_REFR;
      sel_req.ba  = 3'd0;
      sel_req.adr = 13'h0000;
    end else begin
      sel_req = init_cmd_i;
    end
  end

  // A10 high makes precharge cover all banks
  always_comb begin
    sel_adr = sel_req.adr;
    if (sel_req.cmd == ddr3_pkg::CMD_PREC) begin
      sel_adr[10] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      gap_q      <= '0;
      rdy_q      <= 1'b0;
      done_q     <= 1'b0;
      src_init_q <= 1'b0;
      pins_q     <= PINS_IDLE;
    end else begin
      rdy_q  <= src_init_q && (gap_q == ddr3_pkg::ddr3_gap_t'(1));  // Gap ends next cycle
      done_q <= accept_ref;  // High while REFRESH is on the pins

      if (accept) begin
        gap_q      <= gap_of(sel_req);
        src_init_q <= accept_init;
        pins_q.cs_n <= 1'b0;  // Selected for one cycle only
        {pins_q.ras_n, pins_q.cas_n, pins_q.we_n} <= sel_req.cmd;
        pins_q.ba  <= sel_req.ba;
        pins_q.adr <= sel_adr;
      end else begin
        pins_q.cs_n <= 1'b1;
        {pins_q.ras_n, pins_q.cas_n, pins_q.we_n} <= ddr3_pkg::CMD_NOP;
        if (!idle) begin
          gap_q <= gap_q - 1'b1;
        end
      end
    end
  end

  assign init_rdy_o = rdy_q;
  assign ref_done_o = done_q;
  assign pins_o     = pins_q;

endmodule

/* hw/ddr3_cfg_top.sv */
module ddr3_cfg_top #(
  parameter int RSTN_CYCLES = 200,
  parameter int CKE_CYCLES  = 500,
  parameter int REFI_CYCLES = 780
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ctl_busy_i,   // Back-pressure from the controller
  output logic                 dfi_reset_n_o,
  output logic                 dfi_cke_o,
  output ddr3_pkg::ddr3_pins_t dfi_pins_o,
  output logic                 ctl_run_o
);

  logic                init_req;
  ddr3_pkg::ddr3_req_t init_cmd;
  logic                init_rdy;
  logic                ref_req;
  logic                ref_done;
  logic                run;

  // Power-up sequence
  ddr3_init_seq #(
    .RSTN_CYCLES (RSTN_CYCLES),
    .CKE_CYCLES  (CKE_CYCLES)
  ) init_seq_i (
    .clock     (clock),
    .reset     (reset),
    .rdy_i     (init_rdy),
    .req_o     (init_req),
    .cmd_o     (init_cmd),
    .reset_n_o (dfi_reset_n_o),
    .cke_o     (dfi_cke_o),
    .run_o     (run)
  );

  ddr3_refresh_timer #(
    .REFI_CYCLES (REFI_CYCLES)
  ) refresh_timer_i (
    .clock  (clock),
    .reset  (reset),
    .run_i  (run),
    .done_i (ref_done),
    .req_o  (ref_req)
  );

  // Sole driver of the command pins
  ddr3_cmd_issue cmd_issue_i (
    .clock      (clock),
    .reset      (reset),
    .run_i      (run),
    .busy_i     (ctl_busy_i),
    .init_req_i (init_req),
    .init_cmd_i (init_cmd),
    .ref_req_i  (ref_req),
    .init_rdy_o (init_rdy),
    .ref_done_o (ref_done),
    .pins_o     (dfi_pins_o)
  );

  assign ctl_run_o = run;

endmodule

/* verification/ddr3_cfg_sva.sv */
module ddr3_cfg_sva (
  input logic                 clock,
  input logic                 reset,
  input logic                 run_i,
  input logic                 init_rdy_i,
  input logic                 ref_done_i,
  input ddr3_pkg::ddr3_pins_t pins_i
);

  int   fail_count = 0;
  logic refresh_on_pins;

  // JEDEC REFRESH is RAS# and CAS# low with WE# high
  assign refresh_on_pins = !pins_i.cs_n &&
                           ({pins_i.ras_n, pins_i.cas_n, pins_i.we_n} == 3'b001);

  cs_single: assert property (@(posedge clock) disable iff (reset)
    !pins_i.cs_n |=> pins_i.cs_n)
    else begin
      $error("cs_n stayed low for more than one cycle");
      fail_count++;
    end

  refresh_after_run: assert property (@(posedge clock) disable iff (reset)
    refresh_on_pins |-> run_i)
    else begin
      $error("REFRESH on the pins while run is low");
      fail_count++;
    end

  // Only one requester may be released per cycle
  rdy_done_apart: assert property (@(posedge clock) disable iff (reset)
    !(init_rdy_i && ref_done_i))
    else begin
      $error("init_rdy_o and ref_done_o high in the same cycle");
      fail_count++;
    end

endmodule

/* verification/ddr3_cfg_checker.sv */
module ddr3_cfg_checker #(
  parameter int RSTN_CYCLES = 40,
  parameter int CKE_CYCLES  = 30,
  parameter int REFI_CYCLES = 300
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 busy_i,
  input  logic                 reset_n_i,
  input  logic                 cke_i,
  input  ddr3_pkg::ddr3_pins_t pins_i,
  input  logic                 run_i,
  output int                   error_count_o,
  output int                   check_count_o
);

  // JEDEC {RAS#, CAS#, WE#} levels
  localparam logic [2:0] PIN_MRS = 3'b000;
  localparam logic [2:0] PIN_REF = 3'b001;
  localparam logic [2:0] PIN_PRE = 3'b010;
  localparam logic [2:0] PIN_ZQC = 3'b110;
  localparam logic [2:0] PIN_NOP = 3'b111;

  localparam int MRS_BA [4] = '{2, 3, 1, 0};  // MR2, MR3, MR1, MR0
  localparam ddr3_pkg::ddr3_adr_t MRS_VAL [4] = '{ddr3_pkg::MR2, ddr3_pkg::MR3,
                                                  ddr3_pkg::MR1, ddr3_pkg::MR0};

  int   errors = 0;
  int   checks = 0;
  int   age = 0;  // Cycles since the last reset cycle
  logic rst_prev = 1'b0;
  logic busy_prev = 1'b0;
  logic armed = 1'b0;
  int   cmd_idx;
  int   last_age;
  int   last_gap;
  int   run_at;
  int   run_age;  // Refresh model
  int   pend;
  int   stall;

  assign error_count_o = errors;
  assign check_count_o = checks;

  task automatic expect_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  function automatic int cmd_gap(input logic [2:0] code, input int ba);
    case (code)
      PIN_MRS: return (ba == 0) ? ddr3_pkg::GAP_MOD : ddr3_pkg::GAP_MRD;
      PIN_ZQC: return ddr3_pkg::GAP_ZQINIT;
      PIN_PRE: return ddr3_pkg::GAP_RP;
      PIN_REF: return ddr3_pkg::GAP_RFC;
      default: return 1;
    endcase
  endfunction

  always @(posedge clock) begin
    logic [2:0] code;
    logic [2:0] exp_code;
    logic       is_cmd;
    logic       ref_seen;
    logic       expire;
    code     = {pins_i.ras_n, pins_i.cas_n, pins_i.we_n};
    is_cmd   = (pins_i.cs_n == 1'b0);
    ref_seen = is_cmd && (code == PIN_REF);
    if (rst_prev) begin
      age      = 1;
      cmd_idx  = 0;
      last_gap = 0;  // No earlier command yet
      run_at   = 0;
      run_age  = 0;
      pend     = 0;
      stall    = 0;
    end else begin
      age++;
    end
    if (armed) begin
      expect_value("power_up_reset_n", age > RSTN_CYCLES, reset_n_i);
      expect_value("power_up_cke", age > RSTN_CYCLES + CKE_CYCLES, cke_i);
      expect_value("run_rise", (run_at != 0) && (age >= run_at), run_i);
      expire = 1'b0;
      if (run_i) begin
        run_age++;
        expire = (run_age % REFI_CYCLES == 0);
      end
      if (is_cmd) begin
        if (!cke_i) report_failure("Command on the pins while CKE is low");
        if (last_gap != 0 && age - last_age < last_gap) begin
          errors++;
          $display("ERROR cmd_gap: expected at least %0d, actual %0d at %0t",
                   last_gap, age - last_age, $time);
        end
        if (cmd_idx < 6) begin
          exp_code = (cmd_idx < 4) ? PIN_MRS : (cmd_idx == 4) ? PIN_ZQC : PIN_PRE;
          expect_value("init_order_cmd", exp_code, code);
          if (cmd_idx < 4) begin
            expect_value("init_order_ba", MRS_BA[cmd_idx], pins_i.ba);
            expect_value("init_order_adr", MRS_VAL[cmd_idx], pins_i.adr);
          end else begin
            expect_value("init_order_a10", 1, pins_i.adr[10]);
          end
          if (cmd_idx == 5) run_at = age + ddr3_pkg::GAP_RP + 1;  // rdy, then run
        end else begin
          expect_value("refresh_only", PIN_REF, code);
        end
        last_age = age;
        last_gap = cmd_gap(code, pins_i.ba);
        cmd_idx++;
      end else begin
        expect_value("deselect_nop", PIN_NOP, code);  // NOP levels between commands
      end
      if (ref_seen) begin
        expect_value("refresh_busy", 0, busy_prev);  // Busy level when it was taken
        expect_value("refresh_run", 1, run_i);
        if (pend == 0) report_failure("REFRESH issued with no expired interval pending");
        else if (!expire) pend--;
      end else if (expire && pend < ddr3_pkg::REFRESH_PENDING_MAX) begin
        pend++;
      end
      if (ref_seen || busy_i || pend == 0) stall = 0;
      else stall++;
      if (stall > ddr3_pkg::GAP_RFC + 3) begin
        report_failure("REFRESH pending but not issued while the bus was free");
        stall = 0;
      end
    end
    armed     = armed || reset;
    rst_prev  = reset;
    busy_prev = busy_i;
  end

endmodule

/* verification/tb_ddr3_cfg.sv */
module tb_ddr3_cfg;

  localparam int RSTN_CYCLES  = 40;
  localparam int CKE_CYCLES   = 30;
  localparam int REFI_CYCLES  = 300;
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES   = 20 * REFI_CYCLES;  // Refresh intervals per run
  // Two init sequences of about 1300 cycles and about 40 intervals, with margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic                 clock;
  logic                 reset;
  logic                 ctl_busy;
  logic                 dfi_reset_n;
  logic                 dfi_cke;
  logic                 ctl_run;
  ddr3_pkg::ddr3_pins_t dfi_pins;
  int                   busy_left;  // Cycles left in the current busy phase
  int                   cycle_count;
  int                   error_count;
  int                   check_count;
  int                   sva_count;

  ddr3_cfg_top #(
    .RSTN_CYCLES (RSTN_CYCLES),
    .CKE_CYCLES  (CKE_CYCLES),
    .REFI_CYCLES (REFI_CYCLES)
  ) dut_i (
    .clock         (clock),
    .reset         (reset),
    .ctl_busy_i    (ctl_busy),
    .dfi_reset_n_o (dfi_reset_n),
    .dfi_cke_o     (dfi_cke),
    .dfi_pins_o    (dfi_pins),
    .ctl_run_o     (ctl_run)
  );

  ddr3_cfg_checker #(
    .RSTN_CYCLES (RSTN_CYCLES),
    .CKE_CYCLES  (CKE_CYCLES),
    .REFI_CYCLES (REFI_CYCLES)
  ) checker_i (
    .clock         (clock),
    .reset         (reset),
    .busy_i        (ctl_busy),
    .reset_n_i     (dfi_reset_n),
    .cke_i         (dfi_cke),
    .pins_i        (dfi_pins),
    .run_i         (ctl_run),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  bind ddr3_cmd_issue ddr3_cfg_sva sva_i (
    .clock      (clock),
    .reset      (reset),
    .run_i      (run_i),
    .init_rdy_i (init_rdy_o),
    .ref_done_i (ref_done_o),
    .pins_i     (pins_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Alternates idle gaps with busy bursts of 0 to 400 cycles
  task automatic step_busy();
    if (busy_left == 0) begin
      if (ctl_busy) begin
        ctl_busy  = 1'b0;
        busy_left = $urandom_range(600, 100);
      end else begin
        busy_left = $urandom_range(400, 0);
        ctl_busy  = (busy_left != 0);
      end
    end else begin
      busy_left--;
    end
  endtask

  task automatic run_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clock);
      step_busy();
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    run_cycles(RESET_CYCLES);
    reset = 1'b0;
  endtask

  task automatic wait_for_run();
    while (!ctl_run) begin
      run_cycles(1);
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the test sequence did not finish", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    reset     = 1'b1;
    ctl_busy  = 1'b0;
    busy_left = 0;
    void'($urandom(32'h4ac180c2));
    apply_reset();
    wait_for_run();
    run_cycles($urandom_range(RUN_CYCLES, 2 * REFI_CYCLES));  // Reset lands mid-run
    apply_reset();
    wait_for_run();
    run_cycles(RUN_CYCLES);
    sva_count = dut_i.cmd_issue_i.sva_i.fail_count;
    $display("Checks: %0d, checker errors: %0d, assertion errors: %0d",
             check_count, error_count, sva_count);
    if (error_count == 0 && sva_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
hw/ddr3_pkg.sv
hw/ddr3_init_seq.sv
hw/ddr3_refresh_timer.sv
hw/ddr3_cmd_issue.sv
hw/ddr3_cfg_top.sv
verification/ddr3_cfg_sva.sv
verification/ddr3_cfg_checker.sv
verification/tb_ddr3_cfg.sv
